// File: verilog.f
rx_pkg.sv
adc_unfold.sv
mm_cdr.sv
prbs_checker.sv
rx_digital_core.sv
rx_digital_core_chk.sv
tb_rx_digital_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rx_digital_core -f verilog.f

out=$(./obj_dir/Vtb_rx_digital_core +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'PASS: all tests'

// File: tb_rx_digital_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rx_digital_core import rx_pkg::*; ();

    logic clk_adc = 1'b0;
    logic rst_n_i;
    logic [Nadc-1:0] adc_mag_i [Nti-1:0];
    logic [Nti-1:0] adc_sign_i;
    logic signed [Nadc-1:0] pd_offset_i [Nti-1:0];
    logic sel_ext_pi_i;
    logic [Npi-1:0] ext_pi_ctl_i;
    logic prbs_en_i;
    logic [Npi-1:0] pi_ctl_o;
    logic [Ncnt-1:0] correct_bits_o;
    logic [Ncnt-1:0] total_bits_o;

    // next clock's stimulus
    logic [Nadc-1:0] next_mag [Nti-1:0];
    logic [Nti-1:0] next_sign;
    logic signed [Nadc-1:0] next_ofs [Nti-1:0];
    logic signed [Nadc-1:0] base_ofs [Nti-1:0];
    // magnitudes already sent meet the offsets one clock later
    logic [Nadc-1:0] last_mag [Nti-1:0];
    logic [Nti-1:0] last_sign;
    // PRBS7 generator with the newest bit in bit 0
    logic [Nprbs-1:0] lfsr;
    // CDR model followed from reset
    int prev_smp;
    logic [Nacc-1:0] acc_model;
    int pend_lane;
    logic pend_sign;
    int flips;
    int cycle_cnt = 0;

    rx_digital_core i_dut (.*);

    always #4 clk_adc = ~clk_adc;

    // the phases take about 1000 cycles
    always @(posedge clk_adc) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 4000) begin
            $display("timeout: run did not finish within 4000 cycles");
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end else if (i_dut.chk_i.failed) begin
            $display("a bound assertion on the DUT failed");
            $display("FAIL: see errors above");
            $fatal(1, "assertion failure");
        end
    end

    task automatic stop_on_mismatch(input string name, input logic [Ncnt-1:0] got,
                                    input logic [Ncnt-1:0] want);
        if (got !== want) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // drives one clock and adds the sample set it produces to the model
    // stimulus ranges keep every sample clear of saturation
    task automatic apply_inputs(input int flip_lane);
        int smp [Nti];
        int prv;
        int d_prv;
        int d_cur;
        int pd;
        if (pend_lane >= 0) begin
            // pushes last clock's sample on this lane across zero
            next_ofs[pend_lane] = pend_sign ? Nadc'(100) : -Nadc'(100);
            flips++;
        end
        pend_lane = flip_lane;
        if (flip_lane >= 0) begin
            pend_sign = next_sign[flip_lane];
        end
        pd = 0;
        for (int k = 0; k < Nti; k++) begin
            smp[k] = last_sign[k] ? int'(last_mag[k]) : -int'(last_mag[k]);
            smp[k] = smp[k] - int'(next_ofs[k]);
        end
        for (int k = 0; k < Nti; k++) begin
            if (k == 0) begin
                prv = prev_smp;
            end else begin
                prv = smp[k-1];
            end
            // decision is +1 for a non-negative sample and -1 otherwise
            d_prv = (prv >= 0) ? 1 : -1;
            d_cur = (smp[k] >= 0) ? 1 : -1;
            pd += d_prv * smp[k] - d_cur * prv;
        end
        prev_smp = smp[Nti-1];
        acc_model = acc_model + Nacc'(pd);
        adc_mag_i = next_mag;
        adc_sign_i = next_sign;
        pd_offset_i = next_ofs;
        last_mag = next_mag;
        last_sign = next_sign;
        @(posedge clk_adc);
        #1;
    endtask

    task automatic send_prbs(input int flip_lane);
        logic b;
        for (int k = 0; k < Nti; k++) begin
            // taps at delays 6 and 7
            b = lfsr[5] ^ lfsr[6];
            lfsr = {lfsr[Nprbs-2:0], b};
            next_sign[k] = b;
            next_mag[k] = Nadc'(16 + $urandom_range(64));
            next_ofs[k] = base_ofs[k];
        end
        apply_inputs(flip_lane);
    endtask

    // lanes +-20/40 with a constant MM error of the chosen sign
    task automatic send_pattern(input logic pos_err);
        for (int k = 0; k < Nti; k++) begin
            next_sign[k] = (k < Nti / 2);
            next_mag[k] = ((k % 2 == 0) == pos_err) ? Nadc'(20) : Nadc'(40);
            next_ofs[k] = '0;
        end
        apply_inputs(-1);
    endtask

    task automatic send_zero();
        next_mag = '{default: '0};
        next_sign = '0;
        next_ofs = '{default: '0};
        apply_inputs(-1);
    endtask

    task automatic run_prbs_phase(input int n_en, input logic with_errors);
        int lane;
        int counted;
        flips = 0;
        for (int k = 0; k < Nti; k++) begin
            base_ofs[k] = Nadc'(int'($urandom_range(30)) - 15);
        end
        repeat (4) send_prbs(-1);
        prbs_en_i = 1'b1;
        for (int c = 0; c < n_en; c++) begin
            lane = -1;
            if (with_errors && c >= 10 && c < n_en - 10 && c % 5 == 0) begin
                lane = int'($urandom_range(Nti - 1));
            end
            send_prbs(lane);
        end
        prbs_en_i = 1'b0;
        repeat (3) send_prbs(-1);
        // skips the enable edge and the clocks that fill Nprbs history bits
        counted = n_en - 1 - (Nprbs + Nti - 1) / Nti;
        stop_on_mismatch("total_bits_o", total_bits_o, Ncnt'(Nti * counted));
        stop_on_mismatch("total_bits_o - correct_bits_o", total_bits_o - correct_bits_o,
                         Ncnt'(3 * flips));
    endtask

    // one PI step of slack
    task automatic check_pi();
        logic [Npi-1:0] want;
        logic [Npi-1:0] diff;
        repeat (8) send_zero();
        want = acc_model[Nacc-1 -: Npi];
        diff = pi_ctl_o - want;
        if (diff > 1 && diff != {Npi{1'b1}}) begin
            $display("Fail pi_ctl_o: got 0x%h, expected 0x%h", pi_ctl_o, want);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        void'($urandom(94));
        rst_n_i = 1'b0;
        adc_mag_i = '{default: '0};
        adc_sign_i = '0;
        pd_offset_i = '{default: '0};
        sel_ext_pi_i = 1'b0;
        ext_pi_ctl_i = '0;
        prbs_en_i = 1'b0;
        last_mag = '{default: '0};
        last_sign = '0;
        lfsr = '1;
        prev_smp = 0;
        acc_model = '0;
        pend_lane = -1;
        pend_sign = 1'b0;
        flips = 0;
        repeat (4) @(posedge clk_adc);
        #1;
        rst_n_i = 1'b1;

        run_prbs_phase(300, 1'b0);
        run_prbs_phase(300, 1'b1);

        // override while the loop keeps integrating random data
        sel_ext_pi_i = 1'b1;
        repeat (40) begin
            ext_pi_ctl_i = Npi'($urandom);
            send_prbs(-1);
        end
        sel_ext_pi_i = 1'b0;
        check_pi();

        repeat (128) send_pattern(1'b1);
        check_pi();
        repeat (128) send_pattern(1'b0);
        check_pi();

        if (i_dut.chk_i.failed) begin
            $display("a bound assertion on the DUT failed");
            $display("FAIL: see errors above");
            $fatal(1, "assertion failure");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rx_digital_core_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rx_digital_core_chk import rx_pkg::*; (
    input wire logic clk_adc,
    input wire logic rst_n_i,
    input wire logic sel_ext_pi_i,
    input wire logic [Npi-1:0] ext_pi_ctl_i,
    input wire logic prbs_en_i,
    input wire logic [Npi-1:0] pi_ctl_o,
    input wire logic [Ncnt-1:0] correct_bits_o,
    input wire logic [Ncnt-1:0] total_bits_o
);

    // sticky, set by any failing assertion
    logic failed = 1'b0;

    a_reset_clear: assert property (@(posedge clk_adc)
        !rst_n_i |=> (pi_ctl_o == '0 && correct_bits_o == '0 && total_bits_o == '0))
    else begin
        failed = 1'b1;
        $error("outputs not cleared by reset");
    end

    // a rising enable clears the counters, so that edge is left out
    a_total_step: assert property (@(posedge clk_adc)
        (rst_n_i && !$rose(prbs_en_i)) |=> (total_bits_o == $past(total_bits_o)
            || total_bits_o == $past(total_bits_o) + Ncnt'(Nti)))
    else begin
        failed = 1'b1;
        $error("total_bits_o moved by neither 0 nor Nti");
    end

    a_correct_step: assert property (@(posedge clk_adc)
        (rst_n_i && !$rose(prbs_en_i)) |=> (correct_bits_o >= $past(correct_bits_o)
            && correct_bits_o <= $past(correct_bits_o) + Ncnt'(Nti)))
    else begin
        failed = 1'b1;
        $error("correct_bits_o grew by more than Nti");
    end

    a_correct_le_total: assert property (@(posedge clk_adc) correct_bits_o <= total_bits_o)
    else begin
        failed = 1'b1;
        $error("correct_bits_o exceeds total_bits_o");
    end

    a_hold_disabled: assert property (@(posedge clk_adc)
        (rst_n_i && !prbs_en_i) |=> ($stable(correct_bits_o) && $stable(total_bits_o)))
    else begin
        failed = 1'b1;
        $error("bit counters moved while the checker was disabled");
    end

    a_override: assert property (@(posedge clk_adc)
        (rst_n_i && sel_ext_pi_i) |=> (pi_ctl_o == $past(ext_pi_ctl_i)))
    else begin
        failed = 1'b1;
        $error("pi_ctl_o does not follow the external word");
    end

endmodule

bind rx_digital_core rx_digital_core_chk chk_i (.*);

`default_nettype wire

// File: rx_digital_core.sv
`timescale 1ns/10ps
`default_nettype none

module rx_digital_core import rx_pkg::*; (
    input wire logic clk_adc,
    input wire logic rst_n_i,
    // interleaved slice outputs
    input wire logic [Nadc-1:0] adc_mag_i [Nti-1:0],
    input wire logic [Nti-1:0] adc_sign_i,
    // per-slice offset, supplied from outside
    input wire logic signed [Nadc-1:0] pd_offset_i [Nti-1:0],
    // PI override
    input wire logic sel_ext_pi_i,
    input wire logic [Npi-1:0] ext_pi_ctl_i,
    // PRBS checker control
    input wire logic prbs_en_i,
    output logic [Npi-1:0] pi_ctl_o,
    output logic [Ncnt-1:0] correct_bits_o,
    output logic [Ncnt-1:0] total_bits_o
);

    // unfolded samples, shared by the CDR and the checker
    logic signed [Nadc-1:0] sample [Nti-1:0];

    adc_unfold unfold_i (
        .clk_adc(clk_adc),
        .rst_n_i(rst_n_i),
        .adc_mag_i(adc_mag_i),
        .adc_sign_i(adc_sign_i),
        .pd_offset_i(pd_offset_i),
        .sample_o(sample)
    );

    // CDR

    mm_cdr cdr_i (
        .clk_adc(clk_adc),
        .rst_n_i(rst_n_i),
        .sample_i(sample),
        .sel_ext_pi_i(sel_ext_pi_i),
        .ext_pi_ctl_i(ext_pi_ctl_i),
        .pi_ctl_o(pi_ctl_o)
    );

    // PRBS

    prbs_checker prbs_checker_i (
        .clk_adc(clk_adc),
        .rst_n_i(rst_n_i),
        .sample_i(sample),
        .prbs_en_i(prbs_en_i),
        .correct_bits_o(correct_bits_o),
        .total_bits_o(total_bits_o)
    );

endmodule

`default_nettype wire

// File: prbs_checker.sv
`timescale 1ns/10ps
`default_nettype none

module prbs_checker import rx_pkg::*; (
    input wire logic clk_adc,
    input wire logic rst_n_i,
    input wire logic signed [Nadc-1:0] sample_i [Nti-1:0],
    input wire logic prbs_en_i,
    output logic [Ncnt-1:0] correct_bits_o,
    output logic [Ncnt-1:0] total_bits_o
);

    logic [Nti-1:0] rx_bits;
    // received bits of earlier clocks, bit 0 is the oldest
    logic [Nprbs-1:0] hist_q;
    // history followed by this clock's lanes in arrival order
    logic [Nprbs+Nti-1:0] seq;
    logic [Nti-1:0] match;
    logic [Ncnt-1:0] n_match;
    logic [Nfill-1:0] fill_q;
    logic en_q;
    logic en_rise;
    logic hist_full;

    assign seq = {rx_bits, hist_q};
    assign en_rise = prbs_en_i && !en_q;
    assign hist_full = (fill_q >= Nfill'(Nprbs));

    for (genvar k = 0; k < Nti; k++) begin : g_lane
        // non-negative sample is a 1
        assign rx_bits[k] = ~sample_i[k][Nadc-1];
        // lane k sits at Nprbs + k, so its taps land at k + 1 and k
        assign match[k] = rx_bits[k] == (seq[k+1] ^ seq[k]);
    end

    always_comb begin
        n_match = '0;
        for (int i = 0; i < Nti; i++) begin
            n_match = n_match + Ncnt'(match[i]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            hist_q <= '0;
            en_q <= 1'b0;
            fill_q <= '0;
            correct_bits_o <= '0;
            total_bits_o <= '0;
        end else begin
            hist_q <= seq[Nprbs+Nti-1:Nti];
            en_q <= prbs_en_i;
            if (en_rise) begin
                fill_q <= '0;
                correct_bits_o <= '0;
                total_bits_o <= '0;
            end else if (prbs_en_i) begin
                if (hist_full) begin
                    correct_bits_o <= correct_bits_o + n_match;
                    total_bits_o <= total_bits_o + Ncnt'(Nti);
                end else begin
                    // predictions are meaningless until Nprbs bits are in
                    fill_q <= fill_q + Nfill'(Nti);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: mm_cdr.sv
`timescale 1ns/10ps
`default_nettype none

module mm_cdr import rx_pkg::*; (
    input wire logic clk_adc,
    input wire logic rst_n_i,
    input wire logic signed [Nadc-1:0] sample_i [Nti-1:0],
    input wire logic sel_ext_pi_i,
    input wire logic [Npi-1:0] ext_pi_ctl_i,
    output logic [Npi-1:0] pi_ctl_o
);

    // last lane of the prior clock, feeds lane 0
    logic signed [Nadc-1:0] last_sample_q;
    logic signed [Nadc-1:0] prev_sample [Nti-1:0];

    logic signed [Npd-1:0] pd_sum;
    logic signed [Npd-1:0] pd_sum_q;

    // phase wheel, wraps freely
    logic [Nacc-1:0] acc_q;

    assign prev_sample[0] = last_sample_q;

    for (genvar k = 1; k < Nti; k++) begin : g_prev
        assign prev_sample[k] = sample_i[k-1];
    end

    // Mueller-Muller error per lane
    //   d(k-1) * s(k) - d(k) * s(k-1), with d = +1 for s >= 0 and -1 otherwise
    // the decisions are +-1, so each product is a conditional negation
    always_comb begin : pd_calc
        logic signed [Npd-1:0] cur_x;
        logic signed [Npd-1:0] prv_x;
        logic signed [Npd-1:0] term;
        pd_sum = '0;
        for (int i = 0; i < Nti; i++) begin
            cur_x = sample_i[i];
            prv_x = prev_sample[i];
            term = (prv_x[Npd-1] ? -cur_x : cur_x) - (cur_x[Npd-1] ? -prv_x : prv_x);
            pd_sum = pd_sum + term;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            last_sample_q <= '0;
            pd_sum_q <= '0;
        end else begin
            last_sample_q <= sample_i[Nti-1];
            pd_sum_q <= pd_sum;
        end
    end

    // integrate, keeps running while the override is selected
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_q + {{(Nacc-Npd){pd_sum_q[Npd-1]}}, pd_sum_q};
        end
    end

    // output register, loop word or external word
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            pi_ctl_o <= '0;
        end else if (sel_ext_pi_i) begin
            pi_ctl_o <= ext_pi_ctl_i;
        end else begin
            pi_ctl_o <= acc_q[Nacc-1 -: Npi];
        end
    end

endmodule

`default_nettype wire

// File: adc_unfold.sv
`timescale 1ns/10ps
`default_nettype none

module adc_unfold import rx_pkg::*; (
    input wire logic clk_adc,
    input wire logic rst_n_i,
    input wire logic [Nadc-1:0] adc_mag_i [Nti-1:0],
    input wire logic [Nti-1:0] adc_sign_i,
    input wire logic signed [Nadc-1:0] pd_offset_i [Nti-1:0],
    output logic signed [Nadc-1:0] sample_o [Nti-1:0]
);

    logic [Nadc-1:0] mag_q [Nti-1:0];
    logic [Nti-1:0] sign_q;

    // sign 1 means positive, then offset removal and clamp to signed range
    function automatic logic signed [Nadc-1:0] unfold_sat(
        input logic [Nadc-1:0] mag,
        input logic sgn,
        input logic signed [Nadc-1:0] ofs
    );
        logic signed [Nadc+1:0] val;
        val = sgn ? $signed({2'b00, mag}) : -$signed({2'b00, mag});
        val = val - ofs;
        // top three bits disagree when the value left the Nadc range
        if (val[Nadc+1:Nadc-1] != {3{val[Nadc-1]}}) begin
            return val[Nadc+1] ? $signed({1'b1, {(Nadc-1){1'b0}}})
                               : $signed({1'b0, {(Nadc-1){1'b1}}});
        end
        return $signed(val[Nadc-1:0]);
    endfunction

    // retime slice outputs onto clk_adc
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            mag_q <= '{default: '0};
            sign_q <= '0;
        end else begin
            mag_q <= adc_mag_i;
            sign_q <= adc_sign_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            sample_o <= '{default: '0};
        end else begin
            for (int k = 0; k < Nti; k++) begin
                sample_o[k] <= unfold_sat(mag_q[k], sign_q[k], pd_offset_i[k]);
            end
        end
    end

endmodule

`default_nettype wire

// File: rx_pkg.sv
package rx_pkg;

    // time-interleaved ADC slices, lane 0 is the oldest sample of a clock
    localparam int Nti = 4;

    // ADC magnitude width, also the width of an unfolded signed sample
    localparam int Nadc = 8;

    // phase interpolator control word
    localparam int Npi = 9;

    // fractional bits kept below the PI word in the loop accumulator
    localparam int Ncdr_frac = 6;
    localparam int Nacc = Npi + Ncdr_frac;

    // summed phase detector output, room for Nti lanes of two terms each
    localparam int Npd = 12;

    // PRBS7, taps at delays 6 and 7
    localparam int Nprbs = 7;

    // history fill counter, holds up to Nprbs + Nti - 1
    localparam int Nfill = $clog2(Nprbs + Nti);

    // correct and total bit counters
    localparam int Ncnt = 32;

endpackage
